// File: tb/obj_vectors.txt
# op name addr data expect, hex; W write, R read, L line at vrender=addr, P pix at hpos=addr
# objects 0-3 on lines 0A-14, obj 4 misses, obj 5 is the end mark hiding obj 6
W o0_range 0000 0A14 0
W o0_xpos 0001 0010 0
W o0_pitch 0002 0004 0
W o0_offset 0003 0000 0
W o0_attr 0004 0301 0
W o1_range 0008 0A14 0
W o1_xpos 0009 0014 0
W o1_pitch 000A 0000 0
W o1_offset 000B 0008 0
W o1_attr 000C 0500 0
W o2_range 0010 0A14 0
W o2_xpos 0011 0028 0
W o2_pitch 0012 0000 0
W o2_offset 0013 0008 0
W o2_attr 0014 0201 0
W o3_range 0018 0A14 0
W o3_xpos 0019 002C 0
W o3_pitch 001A 0000 0
W o3_offset 001B 800C 0
W o3_attr 001C 0401 0
W o4_range 0020 3040 0
W o5_range 0028 00FF 0
W o6_range 0030 0A14 0
W o6_xpos 0031 00C8 0
W o6_attr 0034 0103 0
W g0 2000 1234 0
W g1 2001 5678 0
W g2 2002 9A0B 0
W g3 2003 CDEF 0
W g4 2004 2222 0
W g5 2005 2222 0
W g6 2006 2222 0
W g7 2007 2222 0
W g8 2008 7777 0
W g9 2009 7777 0
W g10 200A 7777 0
W g11 200B 7777 0
W g12 200C 0123 0
W g13 200D 4567 0
W g14 200E 89AB 0
W g15 200F CDEF 0
R rd_table 0000 0 0A14
R rd_gfx 200E 0 89AB
L line10 000A 0 0
P l10_x15 000F 0 0000
P l10_x16 0010 0 0031
P l10_x25 0019 0 003A
P l10_x26_under 001A 0 0057
P l10_x31_prio 001F 0 003F
P l10_x32 0020 0 0057
P l10_x36 0024 0 0000
P l10_x40 0028 0 0027
P l10_x44_later 002C 0 004F
P l10_x55_flip 0037 0 0044
P l10_x58_flip 003A 0 0041
P l10_x59 003B 0 0000
P l10_miss 0064 0 0000
P l10_endmark 00C8 0 0000
R work_line10 0007 0 0004
L line11 000B 0 0
P l11_x16 0010 0 0032
P l11_x26 001A 0 0032
P l11_x32 0020 0 0057
R work_line11 0007 0 0008
L line300 012C 0 0
P blank_x16 0010 0 0000
P blank_x44 002C 0 0000

// File: build.f
logic/obj_pkg.sv
logic/obj_mem.sv
logic/obj_scan.sv
logic/obj_draw.sv
logic/obj_linebuf.sv
logic/obj_top.sv
tb/obj_assertions.sv
tb/obj_checker.sv
tb/obj_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module obj_tb -o obj_sim \
    && ./obj_dir/obj_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

// File: tb/obj_tb.sv
// Runs tb/obj_vectors.txt from the project root; each L op sweeps hpos to clear stale line buffer data
module obj_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [13:0] wb_adr;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic        wb_ack;
    logic        hstart;
    logic [8:0]  vrender;
    logic [8:0]  hpos;
    logic [9:0]  pix;

    // Checker requests
    logic            rd_chk;
    logic            pix_chk;
    logic [15:0]     exp_val;
    logic [8*16-1:0] test_name;
    int              chk_errors;
    int              chk_count;

    int   tb_errors;
    logic abort;

    always #50 clk = ~clk;  // 100 ns period

    obj_top #(.OBJ_AW(7), .GFX_AW(12)) DUT (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .hstart, .vrender, .hpos, .pix
    );

    obj_checker u_chk (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_ack, .wb_dat_r, .pix,
        .rd_chk, .pix_chk, .exp_val, .test_name,
        .errors(chk_errors), .checks(chk_count)
    );

    bind obj_top obj_assertions u_asrt (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_ack, .dr_start, .dr_busy, .px_we, .tbl_we
    );

    // Inputs change 5 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    // One classic transfer, stb dropped after ack
    task automatic host_xfer(input logic we, input logic [13:0] adr, input logic [15:0] dat,
                             input logic [15:0] expv, input logic [8*16-1:0] name);
        int n;
        n         = 0;
        wb_cyc    = 1'b1;
        wb_stb    = 1'b1;
        wb_we     = we;
        wb_adr    = adr;
        wb_dat_w  = dat;
        rd_chk    = ~we;
        exp_val   = expv;
        test_name = name;
        do begin
            next_cycle();
            n++;
        end while (!wb_ack && n < 16);
        if (!wb_ack) begin
            $display("Host port gave no ack within 16 cycles in %0s", name);
            tb_errors++;
            abort = 1'b1;
        end else begin
            next_cycle();  // Checker samples ack at this edge
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        rd_chk = 1'b0;
        next_cycle();  // Idle edge so ack clears before the next strobe
    endtask

    // Clear old playback, draw line, then swap so it plays back
    task automatic run_line(input logic [8:0] line);
        for (int i = 0; i < 512; i++) begin
            hpos = 9'(i);  // Erase on read
            next_cycle();
        end
        vrender = line;
        hstart  = 1'b1;
        next_cycle();
        hstart = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            next_cycle();  // Line budget
        end
        vrender = 9'h1FF;  // Scanner stays idle on the swap
        hstart  = 1'b1;
        next_cycle();
        hstart = 1'b0;
    endtask

    task automatic pix_check(input logic [8:0] x, input logic [15:0] expv,
                             input logic [8*16-1:0] name);
        hpos = x;
        next_cycle();  // pix registered at this edge
        pix_chk   = 1'b1;
        exp_val   = expv;
        test_name = name;
        next_cycle();
        pix_chk = 1'b0;
    endtask

    initial begin
        int                fd;
        int                rc;
        logic [8*8-1:0]    op;
        logic [8*16-1:0]   name;
        logic [15:0]       adr;
        logic [15:0]       dat;
        logic [15:0]       expv;
        logic [8*128-1:0]  junk;
        clk       = 1'b0;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        hstart    = 1'b0;
        vrender   = 9'h1FF;
        hpos      = '0;
        rd_chk    = 1'b0;
        pix_chk   = 1'b0;
        exp_val   = '0;
        test_name = "reset";
        tb_errors = 0;
        abort     = 1'b0;
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;
        next_cycle();

        fd = $fopen("tb/obj_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/obj_vectors.txt");
            tb_errors++;
            abort = 1'b1;
        end
        while (!abort && !$feof(fd)) begin
            rc = $fscanf(fd, "%s", op);
            if (rc != 1) begin
                break;
            end
            if (op == "#") begin
                rc = $fgets(junk, fd);  // Comment line
            end else begin
                rc = $fscanf(fd, "%s %h %h %h", name, adr, dat, expv);
                case (op)
                    "W": host_xfer(1'b1, adr[13:0], dat, expv, name);
                    "R": host_xfer(1'b0, adr[13:0], dat, expv, name);
                    "L": run_line(adr[8:0]);
                    "P": pix_check(adr[8:0], expv, name);
                    default: begin
                        $display("Unknown opcode in vector file");
                        tb_errors++;
                    end
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        repeat (2) next_cycle();
        $display("Checks %0d, checker errors %0d, testbench errors %0d",
                 chk_count, chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tb/obj_checker.sv
// Samples on rising edges; expects the testbench to raise a request one cycle before capture
module obj_checker (
    input  logic            clk,
    input  logic            rst,
    input  logic            wb_cyc,
    input  logic            wb_stb,
    input  logic            wb_ack,
    input  logic [15:0]     wb_dat_r,
    input  logic [9:0]      pix,
    input  logic            rd_chk,     // Read data to compare on ack
    input  logic            pix_chk,    // Compare pix this edge
    input  logic [15:0]     exp_val,
    input  logic [8*16-1:0] test_name,
    output int              errors,
    output int              checks
);
    timeunit 1ns;
    timeprecision 1ps;

    int wait_cnt;  // Edges with strobe up and no ack

    initial begin
        errors   = 0;
        checks   = 0;
        wait_cnt = 0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (wb_ack) begin
                checks++;
                if (wait_cnt != 1) begin  // Ack due on second edge after strobe
                    errors++;
                    $display("FAILED %0s ack latency expected 2 actual %0d",
                             test_name, wait_cnt + 1);
                end
                if (rd_chk) begin
                    checks++;
                    if (wb_dat_r !== exp_val) begin
                        errors++;
                        $display("FAILED %0s expected %h actual %h",
                                 test_name, exp_val, wb_dat_r);
                    end
                end
            end else if (wb_cyc && wb_stb) begin
                wait_cnt++;
            end
            if (!(wb_cyc && wb_stb)) begin
                wait_cnt = 0;
            end
            if (pix_chk) begin
                checks++;
                if (pix !== exp_val[9:0]) begin  // Palette and color
                    errors++;
                    $display("FAILED %0s expected %h actual %h",
                             test_name, exp_val[9:0], pix);
                end
            end
        end
    end

endmodule

// File: tb/obj_assertions.sv
// Bound into obj_top; handshake rules only, pixel values are left to the checker
module obj_assertions (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic dr_start,
    input logic dr_busy,
    input logic px_we,
    input logic tbl_we
);
    timeunit 1ns;
    timeprecision 1ps;

    // Ack needs strobe held since the edge before
    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb && $past(wb_cyc && wb_stb)))
        else $error("Ack without cycle and strobe held from the edge before");

    start_when_free: assert property (@(posedge clk) disable iff (rst)
        dr_start |-> !dr_busy)
        else $error("Draw start while drawer busy");

    pixel_in_draw: assert property (@(posedge clk) disable iff (rst)
        px_we |-> dr_busy)
        else $error("Pixel write outside a draw");

    // Scanner must not write the table straight out of reset
    quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !tbl_we)
        else $error("Table write right after reset");

endmodule

// File: logic/obj_top.sv
// Objects for vrender appear at pix one line later, after the following hstart swaps buffers
module obj_top #(
    parameter int OBJ_AW = 7,
    parameter int GFX_AW = 12
) (
    input  logic        clk,
    input  logic        rst,
    // Host port
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [13:0] wb_adr,
    input  logic [15:0] wb_dat_w,
    output logic [15:0] wb_dat_r,
    output logic        wb_ack,
    // Video timing
    input  logic        hstart,
    input  logic [8:0]  vrender,
    input  logic [8:0]  hpos,
    output logic [9:0]  pix
);

    // Scanner to table
    logic [OBJ_AW+obj_pkg::WIDX_W-1:0] tbl_addr;
    logic [15:0]                       tbl_din;
    logic [15:0]                       tbl_dout;
    logic                              tbl_we;

    // Scanner to drawer
    logic                 dr_start;
    logic                 dr_busy;
    logic [8:0]           dr_xpos;
    obj_pkg::obj_offset_u dr_offset;
    logic [1:0]           dr_bank;
    logic [1:0]           dr_prio;
    logic [5:0]           dr_pal;

    // Drawer to graphics and line buffer
    logic [GFX_AW-1:0] gfx_addr;
    logic [15:0]       gfx_dout;
    logic              px_we;
    logic [8:0]        px_x;
    logic [3:0]        px_color;
    logic [5:0]        px_pal;
    logic [1:0]        px_prio;

    obj_mem #(.OBJ_AW(OBJ_AW), .GFX_AW(GFX_AW)) u_mem (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .tbl_addr, .tbl_din, .tbl_we, .tbl_dout,
        .gfx_addr, .gfx_dout
    );

    obj_scan #(.OBJ_AW(OBJ_AW)) u_scan (
        .clk, .rst,
        .tbl_addr, .tbl_dout, .tbl_din, .tbl_we,
        .dr_start, .dr_busy, .dr_xpos, .dr_offset, .dr_bank, .dr_prio, .dr_pal,
        .hstart, .vrender
    );

    obj_draw #(.GFX_AW(GFX_AW)) u_draw (
        .clk, .rst,
        .dr_start, .dr_xpos, .dr_offset, .dr_bank, .dr_prio, .dr_pal, .dr_busy,
        .gfx_addr, .gfx_dout,
        .px_we, .px_x, .px_color, .px_pal, .px_prio
    );

    obj_linebuf u_linebuf (
        .clk, .rst, .hstart,
        .px_we, .px_x, .px_color, .px_pal, .px_prio,
        .hpos, .pix
    );

endmodule

// File: logic/obj_linebuf.sv
// Playback erases only entries that hpos visits, so hpos must sweep the whole line each line
module obj_linebuf (
    input  logic       clk,
    input  logic       rst,
    input  logic       hstart,
    // Pixel writes from the drawer
    input  logic       px_we,
    input  logic [8:0] px_x,
    input  logic [3:0] px_color,
    input  logic [5:0] px_pal,
    input  logic [1:0] px_prio,
    // Playback
    input  logic [8:0] hpos,
    output logic [9:0] pix
);

    // Entry is {prio, pal, color}; color 0 is transparent
    logic [11:0] line_mem [1024];

    logic        sel;      // Half being drawn
    logic [9:0]  wr_addr;
    logic [9:0]  rd_addr;
    logic [11:0] old;      // Pixel already in the draw half
    logic        replace;

    assign wr_addr = {sel, px_x};
    assign rd_addr = {~sel, hpos};
    assign old     = line_mem[wr_addr];

    // Equal priority lets the later object through
    assign replace = px_we && ((old[3:0] == 4'd0) || (old[11:10] <= px_prio));

    // Both halves start blank
    initial begin
        for (int i = 0; i < 1024; i++) begin
            line_mem[i] = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
            pix <= '0;
        end else begin
            if (hstart) begin
                sel <= ~sel;  // Swap halves
            end
            pix <= line_mem[rd_addr][9:0];  // Palette and color, 0 when empty
        end
    end

    always_ff @(posedge clk) begin
        if (replace) begin
            line_mem[wr_addr] <= {px_prio, px_pal, px_color};
        end
        line_mem[rd_addr] <= '0;  // Erase on read, other half so no clash
    end

endmodule

// File: logic/obj_draw.sv
// Fixed 16-pixel width, 4bpp; pixels past x 511 are dropped, no wrap to the left edge
module obj_draw #(
    parameter int GFX_AW = 12
) (
    input  logic                  clk,
    input  logic                  rst,
    // Command from scanner
    input  logic                  dr_start,
    input  logic [8:0]            dr_xpos,
    input  obj_pkg::obj_offset_u  dr_offset,
    input  logic [1:0]            dr_bank,
    input  logic [1:0]            dr_prio,
    input  logic [5:0]            dr_pal,
    output logic                  dr_busy,
    // Graphics RAM
    output logic [GFX_AW-1:0]     gfx_addr,
    input  logic [15:0]           gfx_dout,
    // Pixel writes
    output logic                  px_we,
    output logic [8:0]            px_x,
    output logic [3:0]            px_color,
    output logic [5:0]            px_pal,
    output logic [1:0]            px_prio
);

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_ADDR = 3'd1;  // First word on the bus
    localparam logic [2:0] ST_LOAD = 3'd2;  // First word arrives
    localparam logic [2:0] ST_EMIT = 3'd3;  // One pixel per cycle
    localparam logic [2:0] ST_DONE = 3'd4;  // Last pixel write in flight

    logic [2:0]        st;
    logic [3:0]        cnt;       // Pixel count
    logic [GFX_AW-1:0] addr_q;
    logic [GFX_AW-1:0] base_addr;
    logic [GFX_AW-1:0] addr_next;
    logic [15:0]       sr;        // Pixel shifter
    logic [9:0]        x;         // Extra bit flags off-line
    logic              flip;
    logic [5:0]        pal;
    logic [1:0]        prio;
    logic [3:0]        nib;

    assign dr_busy   = (st != ST_IDLE);
    assign gfx_addr  = addr_q;
    // Flipped rows start at the last word and walk down
    assign base_addr = {dr_bank, dr_offset.f.addr[GFX_AW-3:0]}
                     + (dr_offset.f.flip ? GFX_AW'(3) : GFX_AW'(0));
    assign addr_next = flip ? addr_q - 1'b1 : addr_q + 1'b1;
    assign nib       = flip ? sr[3:0] : sr[15:12];  // Leftmost pixel is high nibble

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st    <= ST_IDLE;
            cnt   <= '0;
            px_we <= 1'b0;
        end else begin
            px_we <= 1'b0;
            case (st)
                ST_IDLE: begin
                    if (dr_start) begin
                        cnt <= '0;
                        st  <= ST_ADDR;
                    end
                end
                ST_ADDR: st <= ST_LOAD;
                ST_LOAD: st <= ST_EMIT;
                ST_EMIT: begin
                    px_we <= (nib != 4'd0) && !x[9];  // Skip transparent and off-line
                    cnt   <= cnt + 1'b1;
                    if (cnt == 4'd15) begin
                        st <= ST_DONE;
                    end
                end
                ST_DONE: st <= ST_IDLE;
                default: st <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            ST_IDLE: begin
                if (dr_start) begin
                    addr_q <= base_addr;
                    flip   <= dr_offset.f.flip;
                    x      <= {1'b0, dr_xpos};
                    pal    <= dr_pal;
                    prio   <= dr_prio;
                end
            end
            ST_LOAD: begin
                sr     <= gfx_dout;
                addr_q <= addr_next;  // Next word fetched during 4 pixels
            end
            ST_EMIT: begin
                px_x     <= x[8:0];
                px_color <= nib;
                px_pal   <= pal;
                px_prio  <= prio;
                x        <= x + 1'b1;
                if (cnt[1:0] == 2'd3) begin
                    sr     <= gfx_dout;  // Word boundary
                    addr_q <= addr_next;
                end else begin
                    sr <= flip ? sr >> 4 : sr << 4;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: logic/obj_scan.sv
// Starts only on hstart at lines up to 223; an hstart arriving mid-walk is ignored, no overrun flag
module obj_scan #(
    parameter int OBJ_AW = 7
) (
    input  logic                               clk,
    input  logic                               rst,
    // Object table
    output logic [OBJ_AW+obj_pkg::WIDX_W-1:0]  tbl_addr,
    input  logic [15:0]                        tbl_dout,
    output logic [15:0]                        tbl_din,
    output logic                               tbl_we,
    // Draw command
    output logic                               dr_start,
    input  logic                               dr_busy,
    output logic [8:0]                         dr_xpos,
    output obj_pkg::obj_offset_u               dr_offset,
    output logic [1:0]                         dr_bank,
    output logic [1:0]                         dr_prio,
    output logic [5:0]                         dr_pal,
    // Video
    input  logic                               hstart,
    input  logic [8:0]                         vrender
);

    // FSM states, data for the word in idx shows up one state later
    localparam logic [3:0] ST_IDLE  = 4'd0;  // Presents obj 0 range
    localparam logic [3:0] ST_RANGE = 4'd1;  // Presents range after a skip
    localparam logic [3:0] ST_CHECK = 4'd2;  // Range arrives
    localparam logic [3:0] ST_GETX  = 4'd3;
    localparam logic [3:0] ST_GETP  = 4'd4;
    localparam logic [3:0] ST_GETO  = 4'd5;
    localparam logic [3:0] ST_GETA  = 4'd6;
    localparam logic [3:0] ST_WB    = 4'd7;  // Work word arrives and is rewritten
    localparam logic [3:0] ST_ISSUE = 4'd8;  // Waits for the drawer

    logic [3:0]                 st;
    logic [OBJ_AW-1:0]          cur_obj;
    logic [obj_pkg::WIDX_W-1:0] idx;
    logic [7:0]                 line;      // Line latched at hstart
    logic                       first;     // Object starts on this line
    logic                       last_obj;
    logic signed [15:0]         pitch;
    logic [15:0]                offset;
    obj_pkg::obj_offset_u       row_off;   // Offset used for this line
    logic                       hit;
    logic                       list_end;

    assign tbl_addr     = {cur_obj, idx};
    assign row_off.word = first ? offset : tbl_dout;
    assign tbl_din      = row_off.word + pitch;       // Next line's offset
    assign tbl_we       = (st == ST_WB);

    // Range word decode
    assign list_end = tbl_dout[7:0] > obj_pkg::END_MARK;
    assign hit      = (tbl_dout[15:8] <= line) && (tbl_dout[7:0] >= line);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= ST_IDLE;
            cur_obj  <= '0;
            idx      <= obj_pkg::W_RANGE;
            dr_start <= 1'b0;
            last_obj <= 1'b0;
        end else begin
            dr_start <= 1'b0;
            case (st)
                ST_IDLE: begin
                    if (hstart && vrender <= {1'b0, obj_pkg::LAST_LINE}) begin
                        idx <= obj_pkg::W_XPOS;
                        st  <= ST_CHECK;
                    end
                end
                ST_RANGE: begin
                    idx <= obj_pkg::W_XPOS;
                    st  <= ST_CHECK;
                end
                ST_CHECK: begin
                    if (list_end || (!hit && &cur_obj)) begin
                        cur_obj <= '0;             // Done for this line
                        idx     <= obj_pkg::W_RANGE;
                        st      <= ST_IDLE;
                    end else if (!hit) begin
                        cur_obj <= cur_obj + 1'b1; // Skip it
                        idx     <= obj_pkg::W_RANGE;
                        st      <= ST_RANGE;
                    end else begin
                        idx <= obj_pkg::W_PITCH;
                        st  <= ST_GETX;
                    end
                end
                ST_GETX: begin
                    idx <= obj_pkg::W_OFFSET;
                    st  <= ST_GETP;
                end
                ST_GETP: begin
                    idx <= obj_pkg::W_ATTR;
                    st  <= ST_GETO;
                end
                ST_GETO: begin
                    idx <= obj_pkg::W_WORK;
                    st  <= ST_GETA;
                end
                ST_GETA: st <= ST_WB;             // idx stays on work word
                ST_WB: begin
                    last_obj <= &cur_obj;
                    cur_obj  <= cur_obj + 1'b1;    // Wraps to 0 after the last
                    idx      <= obj_pkg::W_RANGE;  // Next range read while waiting
                    st       <= ST_ISSUE;
                end
                ST_ISSUE: begin
                    if (!dr_busy) begin            // Back-pressure point
                        dr_start <= 1'b1;
                        idx      <= last_obj ? obj_pkg::W_RANGE : obj_pkg::W_XPOS;
                        st       <= last_obj ? ST_IDLE : ST_CHECK;
                    end
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    // Command payload, drawer has latched the old one before these change
    always_ff @(posedge clk) begin
        case (st)
            ST_IDLE:  line <= vrender[7:0];
            ST_CHECK: first <= (tbl_dout[15:8] == line);
            ST_GETX:  dr_xpos <= tbl_dout[8:0];
            ST_GETP:  pitch <= tbl_dout;
            ST_GETO:  offset <= tbl_dout;
            ST_GETA: begin
                dr_pal  <= tbl_dout[13:8];
                dr_bank <= tbl_dout[5:4];
                dr_prio <= tbl_dout[1:0];
            end
            ST_WB:    dr_offset <= row_off;
            default: ;
        endcase
    end

endmodule

// File: logic/obj_mem.sv
// Host writes to the object table beat a scanner write to the same word; no byte selects, 16-bit only
module obj_mem #(
    parameter int OBJ_AW = 7,
    parameter int GFX_AW = 12
) (
    input  logic                                  clk,
    input  logic                                  rst,
    // Host port
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [13:0]                           wb_adr,
    input  logic [15:0]                           wb_dat_w,
    output logic [15:0]                           wb_dat_r,
    output logic                                  wb_ack,
    // Scanner port
    input  logic [OBJ_AW+obj_pkg::WIDX_W-1:0]     tbl_addr,
    input  logic [15:0]                           tbl_din,
    input  logic                                  tbl_we,
    output logic [15:0]                           tbl_dout,
    // Drawer port
    input  logic [GFX_AW-1:0]                     gfx_addr,
    output logic [15:0]                           gfx_dout
);

    localparam int TAW = OBJ_AW + $clog2(obj_pkg::WORDS_PER_OBJ);  // Table address bits

    logic [15:0] tbl_mem [2**TAW];
    logic [15:0] gfx_mem [2**GFX_AW];

    logic        host_req;   // Cycle and strobe both up
    logic        host_wr;    // First cycle of a write
    logic        ack_q;
    logic        sel_gfx_q;  // Region of the pending read
    logic [15:0] tbl_rd_q;
    logic [15:0] gfx_rd_q;

    assign host_req = wb_cyc & wb_stb;
    assign host_wr  = host_req & wb_we & ~ack_q;  // Write once per transfer

    // Ack drops the moment strobe goes away
    assign wb_ack   = ack_q & host_req;
    assign wb_dat_r = sel_gfx_q ? gfx_rd_q : tbl_rd_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= host_req;  // One cycle after strobe
        end
    end

    // Object table, scanner side first so host write lands last
    always_ff @(posedge clk) begin
        if (tbl_we) begin
            tbl_mem[tbl_addr] <= tbl_din;
        end
        if (host_wr && !wb_adr[13]) begin
            tbl_mem[wb_adr[TAW-1:0]] <= wb_dat_w;
        end
        tbl_dout <= tbl_mem[tbl_addr];
        tbl_rd_q <= tbl_mem[wb_adr[TAW-1:0]];
    end

    // Graphics RAM
    always_ff @(posedge clk) begin
        if (host_wr && wb_adr[13]) begin
            gfx_mem[wb_adr[GFX_AW-1:0]] <= wb_dat_w;
        end
        gfx_dout  <= gfx_mem[gfx_addr];          // Drawer read
        gfx_rd_q  <= gfx_mem[wb_adr[GFX_AW-1:0]];
        sel_gfx_q <= wb_adr[13];
    end

endmodule

// File: logic/obj_pkg.sv
// Object entries are 8 words, unused words 5 and 6 are free for the host; offset MSB doubles as flip
package obj_pkg;

    // Object table geometry
    localparam int WORDS_PER_OBJ = 8;
    localparam int WIDX_W        = $clog2(WORDS_PER_OBJ);  // Word index bits

    // Word index within an entry
    localparam logic [WIDX_W-1:0] W_RANGE  = WIDX_W'(0);  // Top high byte, bottom low byte
    localparam logic [WIDX_W-1:0] W_XPOS   = WIDX_W'(1);  // Bits 8:0 used
    localparam logic [WIDX_W-1:0] W_PITCH  = WIDX_W'(2);  // Signed row step
    localparam logic [WIDX_W-1:0] W_OFFSET = WIDX_W'(3);  // Row offset on top line
    localparam logic [WIDX_W-1:0] W_ATTR   = WIDX_W'(4);  // Pal 13:8, bank 5:4, prio 1:0
    localparam logic [WIDX_W-1:0] W_WORK   = WIDX_W'(7);  // Running offset, scanner owned

    // Bottom byte above this ends the list
    localparam logic [7:0] END_MARK  = 8'hF0;
    // Last visible line, scanner idles beyond it
    localparam logic [7:0] LAST_LINE = 8'd223;

    // Offset word, summed as a number or split into flip and address
    typedef union packed {
        logic [15:0] word;      // Plain view for pitch add
        struct packed {
            logic        flip;  // Horizontal flip
            logic [14:0] addr;  // Graphics word address
        } f;
    } obj_offset_u;

endpackage
